// ==== verilog/tcore_pkg.sv ====
// Shared types and constants for the single-clock 10G transmit path.
// Beat byte 0 is data[7:0] and goes out on XGMII lane 0.
package tcore_pkg;

	// ======================================================================
	// buffer sizing
	// ======================================================================
	localparam int TX_FIFO_DEPTH = 16;	// beat entries, also host credits after reset
	localparam int TX_FIFO_AW = 4;	// pointer width, log2 of depth

	// ======================================================================
	// XGMII characters
	// ======================================================================
	localparam logic [7:0] XGMII_IDLE = 8'h07;	// control
	localparam logic [7:0] XGMII_START = 8'hFB;	// control, lane 0 only
	localparam logic [7:0] XGMII_TERM = 8'hFD;	// control
	localparam logic [7:0] XGMII_PREAMBLE = 8'h55;	// data
	localparam logic [7:0] XGMII_SFD = 8'hD5;	// data, lane 7 of start word

	// ======================================================================
	// bundles
	// ======================================================================
	// one host beat, 72 bits
	typedef struct packed {
		logic [63:0] data;	// byte 0 in [7:0], sent first
		logic sop;	// opens a packet
		logic eop;	// closes a packet
		logic [2:0] last_bytes;	// valid bytes on eop beat, 0 means 8
		logic [2:0] rsvd;	// always 0
	} tx_beat_t;

	// one XGMII transfer, 72 bits
	typedef struct packed {
		logic [63:0] txd;	// lane n in [8n+7:8n]
		logic [7:0] txc;	// 1 = control char in that lane
	} xgmii_word_t;

	// credits handed back per cycle, 0..2
	typedef logic [1:0] credit_t;

	// wrapping statistics counter
	typedef logic [31:0] cnt32_t;

endpackage

// ==== verilog/tx_ingress.sv ====
// Host beat framing check. Bad beats are dropped and their credit goes back;
// a dropped sop beat leaves the open packet open.
module tx_ingress (
	input logic usr_clk,
	input logic usr_rst_,
	input logic beat_valid,	// costs one host credit
	input tcore_pkg::tx_beat_t beat,
	output logic wr_en,	// to buffer, 1 cycle after sample
	output tcore_pkg::tx_beat_t wr_beat,
	output logic drop_credit,	// 1 cycle after a bad beat
	output tcore_pkg::cnt32_t frame_err_cnt
);

	logic pkt_open;	// between sop and eop
	logic beat_ok;	// sop exactly when no packet open
	logic beat_good;
	logic beat_bad;

	// sop with nothing open, or continuation of an open packet
	assign beat_ok = beat.sop ^ pkt_open;
	assign beat_good = beat_valid & beat_ok;
	assign beat_bad = beat_valid & ~beat_ok;

	// ======================================================================
	// framing state and strobes
	// ======================================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			pkt_open <= 1'b0;
			wr_en <= 1'b0;
			drop_credit <= 1'b0;
			frame_err_cnt <= '0;
		end
		else
		begin
			wr_en <= beat_good;
			drop_credit <= beat_bad;	// credit for the dropped beat
			if (beat_good)
			begin
				pkt_open <= ~beat.eop;	// eop closes, otherwise stays/becomes open
			end
			if (beat_bad)
			begin
				frame_err_cnt <= frame_err_cnt + 32'd1;	// wraps
			end
		end
	end

	// ======================================================================
	// payload toward the buffer
	// ======================================================================
	always_ff @(posedge usr_clk)
	begin
		if (beat_good)
		begin
			wr_beat.data <= beat.data;
			wr_beat.sop <= beat.sop;
			wr_beat.eop <= beat.eop;
			wr_beat.last_bytes <= beat.last_bytes;
			wr_beat.rsvd <= 3'b000;	// force reserved bits clean
		end
	end

endmodule

// ==== verilog/tx_pkt_fifo.sv ====
// Beat FIFO without overflow guard; the host credit rule keeps it from filling up.
// head shows the oldest entry combinationally, pop must only come with a packet stored.
module tx_pkt_fifo (
	input logic usr_clk,
	input logic usr_rst_,
	input logic wr_en,	// store wr_beat at this edge
	input tcore_pkg::tx_beat_t wr_beat,
	input logic pop,	// consume head at this edge
	output tcore_pkg::tx_beat_t head,
	output logic pkt_ready,	// at least one whole packet stored
	output logic pop_credit	// one credit per popped beat
);

	tcore_pkg::tx_beat_t mem [tcore_pkg::TX_FIFO_DEPTH];	// beat storage

	logic [tcore_pkg::TX_FIFO_AW-1:0] wr_ptr;
	logic [tcore_pkg::TX_FIFO_AW-1:0] rd_ptr;
	logic [tcore_pkg::TX_FIFO_AW:0] pkt_cnt;	// complete packets, up to depth
	logic pkt_in;	// eop beat going in
	logic pkt_out;	// eop beat going out

	assign head = mem[rd_ptr];	// first word fall through
	assign pkt_ready = (pkt_cnt != '0);
	assign pkt_in = wr_en & wr_beat.eop;
	assign pkt_out = pop & head.eop;

	// ======================================================================
	// storage
	// ======================================================================
	always_ff @(posedge usr_clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= wr_beat;
		end
	end

	// ======================================================================
	// pointers, packet count, credit return
	// ======================================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			pkt_cnt <= '0;
			pop_credit <= 1'b0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			end
			if (pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			pop_credit <= pop;	// credit 1 cycle after the pop

			// one packet may land and one leave in the same cycle
			case ({pkt_in, pkt_out})
				2'b10:
				begin
					pkt_cnt <= pkt_cnt + 1'b1;
				end
				2'b01:
				begin
					pkt_cnt <= pkt_cnt - 1'b1;
				end
				default:
				begin
					pkt_cnt <= pkt_cnt;	// none or both
				end
			endcase
		end
	end

endmodule

// ==== verilog/xgmii_tx_encap.sv ====
// XGMII frame builder for whole buffered packets; no CRC, no pause frames.
// At least one idle word after each frame; no back-pressure from the XGMII side.
module xgmii_tx_encap (
	input logic usr_clk,
	input logic usr_rst_,
	input logic pkt_ready,	// whole packet waiting in buffer
	input tcore_pkg::tx_beat_t head,
	output logic pop,
	output tcore_pkg::xgmii_word_t xgmii,	// registered
	output tcore_pkg::cnt32_t tx_pkt_cnt,
	output tcore_pkg::cnt32_t tx_byte_cnt
);

	// state names the word sitting on xgmii
	typedef enum logic [2:0] {
		ST_IDLE,	// idle, no frame pending
		ST_START,	// start + preamble + sfd
		ST_DATA,	// one beat
		ST_TERM,	// terminate in lane 0 after a full eop beat
		ST_GAP	// mandatory idle after a frame
	} encap_state_t;

	encap_state_t state_q;
	encap_state_t state_d;
	tcore_pkg::xgmii_word_t word_d;	// next output word
	logic sent_eop;	// last data word was an eop beat
	logic sent_full;	// ... and had all 8 bytes
	logic tail;	// head is a short eop beat, terminate inside it
	logic [3:0] beat_bytes;	// valid bytes of head
	tcore_pkg::cnt32_t frame_bytes;	// bytes of earlier beats in this frame

	assign tail = head.eop & (head.last_bytes != 3'd0);
	assign beat_bytes = tail ? {1'b0, head.last_bytes} : 4'd8;
	assign pop = (state_d == ST_DATA);	// every data word consumes a beat

	// ======================================================================
	// next state
	// ======================================================================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (pkt_ready) state_d = ST_START;
			ST_START: state_d = ST_DATA;
			ST_DATA: if (sent_eop) state_d = sent_full ? ST_TERM : ST_GAP;
			ST_TERM: state_d = ST_GAP;
			ST_GAP: state_d = pkt_ready ? ST_START : ST_IDLE;	// back to back after 1 idle
			default: state_d = ST_IDLE;
		endcase
	end

	// ======================================================================
	// lane builder
	// ======================================================================
	always_comb
	begin
		word_d.txd = {8{tcore_pkg::XGMII_IDLE}};	// all idle by default
		word_d.txc = 8'hFF;
		case (state_d)
			ST_START:
			begin
				word_d.txd = {tcore_pkg::XGMII_SFD, {6{tcore_pkg::XGMII_PREAMBLE}},
					tcore_pkg::XGMII_START};
				word_d.txc = 8'h01;	// only lane 0 is control
			end
			ST_DATA:
			begin
				for (int i = 0; i < 8; i++)
				begin
					if (!tail || (i < int'(head.last_bytes)))
					begin
						word_d.txd[i*8 +: 8] = head.data[i*8 +: 8];
						word_d.txc[i] = 1'b0;
					end
					else if (i == int'(head.last_bytes))
					begin
						word_d.txd[i*8 +: 8] = tcore_pkg::XGMII_TERM;	// idle above
					end
				end
			end
			ST_TERM: word_d.txd[7:0] = tcore_pkg::XGMII_TERM;
			default: ;	// idle or gap word
		endcase
	end

	// ======================================================================
	// registers
	// ======================================================================
	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			state_q <= ST_IDLE;
			xgmii.txd <= {8{tcore_pkg::XGMII_IDLE}};	// idle out of reset
			xgmii.txc <= 8'hFF;
			sent_eop <= 1'b0;
			sent_full <= 1'b0;
			frame_bytes <= '0;
			tx_pkt_cnt <= '0;
			tx_byte_cnt <= '0;
		end
		else
		begin
			state_q <= state_d;
			xgmii <= word_d;
			if (pop)
			begin
				sent_eop <= head.eop;
				sent_full <= head.eop & ~tail;
				if (head.eop)
				begin
					// frame done, preamble not counted
					tx_pkt_cnt <= tx_pkt_cnt + 32'd1;
					tx_byte_cnt <= tx_byte_cnt + frame_bytes + {28'd0, beat_bytes};
					frame_bytes <= '0;
				end
				else
				begin
					frame_bytes <= frame_bytes + 32'd8;
				end
			end
		end
	end

endmodule

// ==== verilog/tcore_fmac_tx.sv ====
// Transmit path top: ingress check, packet buffer, XGMII encapsulator.
// Host must start with TX_FIFO_DEPTH credits and spend one per valid beat.
module tcore_fmac_tx (
	input logic usr_clk,
	input logic usr_rst_,
	input logic beat_valid,
	input tcore_pkg::tx_beat_t beat,
	output tcore_pkg::credit_t credit_ret,	// 0..2 per cycle
	output tcore_pkg::xgmii_word_t xgmii,
	output tcore_pkg::cnt32_t tx_pkt_cnt,
	output tcore_pkg::cnt32_t tx_byte_cnt,
	output tcore_pkg::cnt32_t frame_err_cnt
);

	logic wr_en;	// ingress -> buffer
	tcore_pkg::tx_beat_t wr_beat;
	logic drop_credit;	// bad beat returned
	logic pop;	// encap -> buffer
	tcore_pkg::tx_beat_t head;
	logic pkt_ready;
	logic pop_credit;	// sent beat returned

	// dropped and sent beats can return together
	assign credit_ret = {1'b0, drop_credit} + {1'b0, pop_credit};

	// ======================================================================
	// producer, buffer, consumer
	// ======================================================================
	tx_ingress u_ingress (
		.usr_clk(usr_clk),
		.usr_rst_(usr_rst_),
		.beat_valid(beat_valid),
		.beat(beat),
		.wr_en(wr_en),
		.wr_beat(wr_beat),
		.drop_credit(drop_credit),
		.frame_err_cnt(frame_err_cnt)
	);

	tx_pkt_fifo u_fifo (
		.usr_clk(usr_clk),
		.usr_rst_(usr_rst_),
		.wr_en(wr_en),
		.wr_beat(wr_beat),
		.pop(pop),
		.head(head),
		.pkt_ready(pkt_ready),
		.pop_credit(pop_credit)
	);

	xgmii_tx_encap u_encap (
		.usr_clk(usr_clk),
		.usr_rst_(usr_rst_),
		.pkt_ready(pkt_ready),
		.head(head),
		.pop(pop),
		.xgmii(xgmii),
		.tx_pkt_cnt(tx_pkt_cnt),
		.tx_byte_cnt(tx_byte_cnt)
	);

endmodule

// ==== tb/tcore_fmac_tx_checker.sv ====
// Protocol assertions on the transmit top ports, bound to every tcore_fmac_tx.
// Credit count assumes the host starts with TX_FIFO_DEPTH credits at reset release.
module tcore_fmac_tx_checker (
	input logic usr_clk,
	input logic usr_rst_,
	input logic beat_valid,
	input tcore_pkg::credit_t credit_ret,
	input tcore_pkg::xgmii_word_t xgmii,
	input tcore_pkg::cnt32_t tx_pkt_cnt,
	input tcore_pkg::cnt32_t tx_byte_cnt,
	input tcore_pkg::cnt32_t frame_err_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;	// failed assertion count
	int outstanding;	// beats sent, credit not yet back
	logic in_frame;	// start seen, terminate not yet
	logic is_start;
	logic has_term;
	logic all_idle;

	always_comb
	begin
		is_start = xgmii.txc[0] && (xgmii.txd[7:0] == tcore_pkg::XGMII_START);
		has_term = 1'b0;
		for (int i = 0; i < 8; i++)
		begin
			if (xgmii.txc[i] && (xgmii.txd[i*8 +: 8] == tcore_pkg::XGMII_TERM))
			begin
				has_term = 1'b1;	// any lane
			end
		end
	end
	assign all_idle = (xgmii.txc == 8'hFF) && (xgmii.txd == {8{tcore_pkg::XGMII_IDLE}});

	always_ff @(posedge usr_clk)
	begin
		if (!usr_rst_)
		begin
			outstanding <= 0;
			in_frame <= 1'b0;
		end
		else
		begin
			outstanding <= outstanding + int'(beat_valid) - int'(credit_ret);
			if (is_start)
			begin
				in_frame <= 1'b1;
			end
			else if (has_term)
			begin
				in_frame <= 1'b0;
			end
		end
	end

	// ======================================================================
	// assertions
	// ======================================================================
	a_idle_after_reset: assert property (@(posedge usr_clk) $rose(usr_rst_) |->
		all_idle && (credit_ret == 0) && (tx_pkt_cnt == 0) && (tx_byte_cnt == 0) &&
		(frame_err_cnt == 0))
		else begin $error("xgmii not idle or counters not zero after reset"); fail_cnt++; end
	a_credit_held: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
		beat_valid |-> (outstanding < tcore_pkg::TX_FIFO_DEPTH))
		else begin $error("beat sent while host held no credit"); fail_cnt++; end
	a_outstanding: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
		(outstanding >= 0) && (outstanding <= tcore_pkg::TX_FIFO_DEPTH))
		else begin $error("outstanding credits out of range"); fail_cnt++; end
	a_term_first: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
		is_start |-> !in_frame)
		else begin $error("start word before terminate of previous frame"); fail_cnt++; end
	a_idle_after_term: assert property (@(posedge usr_clk) disable iff (!usr_rst_)
		has_term |=> all_idle)
		else begin $error("terminate not followed by an idle word"); fail_cnt++; end

endmodule

bind tcore_fmac_tx tcore_fmac_tx_checker u_chk (
	.usr_clk(usr_clk),
	.usr_rst_(usr_rst_),
	.beat_valid(beat_valid),
	.credit_ret(credit_ret),
	.xgmii(xgmii),
	.tx_pkt_cnt(tx_pkt_cnt),
	.tx_byte_cnt(tx_byte_cnt),
	.frame_err_cnt(frame_err_cnt)
);

// ==== tb/tb_tcore_fmac_tx.sv ====
// Drives packets under host credits and compares every non-idle XGMII word.
// Packets stay at 8 beats or less so a whole packet always fits the buffer.
module tb_tcore_fmac_tx;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 2000;	// cycles per wait loop

	logic usr_clk;
	logic usr_rst_;
	logic beat_valid;
	tcore_pkg::tx_beat_t beat;
	tcore_pkg::credit_t credit_ret;
	tcore_pkg::xgmii_word_t xgmii;
	tcore_pkg::cnt32_t tx_pkt_cnt;
	tcore_pkg::cnt32_t tx_byte_cnt;
	tcore_pkg::cnt32_t frame_err_cnt;

	int beats_sent = 0;	// good and dropped
	int ret_total = 0;	// credits seen on credit_ret
	int exp_pkts = 0;
	int exp_bytes = 0;
	int exp_drops = 0;
	int err_cnt = 0;
	bit timed_out = 1'b0;
	tcore_pkg::xgmii_word_t exp_q[$];	// expected non-idle words

	tcore_fmac_tx dut (
		.usr_clk(usr_clk),
		.usr_rst_(usr_rst_),
		.beat_valid(beat_valid),
		.beat(beat),
		.credit_ret(credit_ret),
		.xgmii(xgmii),
		.tx_pkt_cnt(tx_pkt_cnt),
		.tx_byte_cnt(tx_byte_cnt),
		.frame_err_cnt(frame_err_cnt)
	);

	initial usr_clk = 1'b0;
	always #5 usr_clk = ~usr_clk;	// 10 ns

	// ======================================================================
	// expected words from the frame rule
	// ======================================================================
	function automatic tcore_pkg::xgmii_word_t start_word();
		tcore_pkg::xgmii_word_t w;
		w.txd = {tcore_pkg::XGMII_SFD, {6{tcore_pkg::XGMII_PREAMBLE}}, tcore_pkg::XGMII_START};
		w.txc = 8'h01;
		return w;
	endfunction

	function automatic tcore_pkg::xgmii_word_t data_word(tcore_pkg::tx_beat_t b);
		tcore_pkg::xgmii_word_t w;
		int k;
		k = (b.eop && (b.last_bytes != 3'd0)) ? int'(b.last_bytes) : 8;
		for (int i = 0; i < 8; i++)
		begin
			w.txd[i*8 +: 8] = (i < k) ? b.data[i*8 +: 8] :
				(i == k) ? tcore_pkg::XGMII_TERM : tcore_pkg::XGMII_IDLE;
			w.txc[i] = (i >= k);	// terminate and idle are control
		end
		return w;
	endfunction

	function automatic int credits();
		return tcore_pkg::TX_FIFO_DEPTH - beats_sent + ret_total;
	endfunction

	// ======================================================================
	// stimulus
	// ======================================================================
	task automatic send_beat(input tcore_pkg::tx_beat_t b);
		int waited;
		waited = 0;
		@(posedge usr_clk);
		#1;
		while ((credits() == 0) && !timed_out)
		begin
			beat_valid = 1'b0;	// hold off, no credit
			@(posedge usr_clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
			begin
				$display("timeout: no credit came back within %0d cycles", TIMEOUT);
				timed_out = 1'b1;
				err_cnt++;
			end
		end
		if (!timed_out)
		begin
			beat_valid = 1'b1;
			beat = b;
			beats_sent++;
		end
	endtask

	task automatic send_stray(input bit sop);
		tcore_pkg::tx_beat_t b;
		b = '0;
		b.data = {$urandom, $urandom};
		b.sop = sop;
		send_beat(b);
		exp_drops++;	// ingress must drop it
	endtask

	task automatic send_pkt(input int nbeats, input logic [2:0] lb, input bit stray_sop);
		tcore_pkg::tx_beat_t b;
		exp_q.push_back(start_word());
		for (int i = 0; i < nbeats; i++)
		begin
			b.data = {$urandom, $urandom};
			b.sop = (i == 0);
			b.eop = (i == nbeats - 1);
			b.last_bytes = b.eop ? lb : 3'd0;
			b.rsvd = 3'd0;
			send_beat(b);
			exp_q.push_back(data_word(b));
			if (stray_sop && (i == 0))
			begin
				send_stray(1'b1);	// sop inside open packet
			end
		end
		if (lb == 3'd0)
		begin
			exp_q.push_back({{7{tcore_pkg::XGMII_IDLE}}, tcore_pkg::XGMII_TERM, 8'hFF});
		end
		exp_pkts++;
		exp_bytes += (nbeats - 1) * 8 + ((lb == 3'd0) ? 8 : int'(lb));
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(posedge usr_clk);
		#1;
		beat_valid = 1'b0;
		while ((exp_q.size() != 0) && !timed_out)
		begin
			@(posedge usr_clk);
			waited++;
			if (waited > TIMEOUT)
			begin
				$display("timeout: frames did not drain within %0d cycles", TIMEOUT);
				timed_out = 1'b1;
				err_cnt++;
			end
		end
		repeat (3) @(posedge usr_clk);	// let the gap word pass
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_counters();
		check_value("tx_pkt_cnt", tx_pkt_cnt, exp_pkts);
		check_value("tx_byte_cnt", tx_byte_cnt, exp_bytes);
		check_value("frame_err_cnt", frame_err_cnt, exp_drops);
		check_value("credit_ret total", ret_total, beats_sent);
	endtask

	// ======================================================================
	// monitor, mid cycle where outputs are settled
	// ======================================================================
	always @(negedge usr_clk)
	begin
		if (usr_rst_)
		begin
			ret_total += int'(credit_ret);
			if (!((xgmii.txc == 8'hFF) && (xgmii.txd == {8{tcore_pkg::XGMII_IDLE}})))
			begin
				if (exp_q.size() == 0)
				begin
					$display("xgmii carried a non-idle word %h with no frame pending", xgmii);
					err_cnt++;
				end
				else
				begin
					if (xgmii !== exp_q[0])
					begin
						$display("mismatch xgmii: got %h expected %h", xgmii, exp_q[0]);
						err_cnt++;
					end
					void'(exp_q.pop_front());
				end
			end
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================
	initial
	begin
		usr_rst_ = 1'b0;
		beat_valid = 1'b0;
		beat = '0;
		void'($urandom(32'hffaa_ac49));
		repeat (2) @(posedge usr_clk);
		#1;
		usr_rst_ = 1'b1;
		repeat (3) @(posedge usr_clk);
		check_counters();	// all zero before any beat

		send_pkt(3, 3'd5, 1'b0);	// short tail
		send_pkt(1, 3'd7, 1'b0);	// one beat packet
		drain();
		check_counters();

		send_pkt(2, 3'd0, 1'b0);	// full tail, own terminate word
		drain();
		check_counters();

		for (int n = 0; n < 12; n++)
		begin
			send_pkt($urandom_range(8, 1), 3'($urandom_range(7, 0)), 1'b0);
		end
		drain();
		check_counters();

		send_stray(1'b0);	// no packet open
		send_pkt(4, 3'd2, 1'b1);
		drain();
		check_counters();

		$display("errors: %0d check failures, %0d assertion failures", err_cnt,
			dut.u_chk.fail_cnt);
		if ((err_cnt == 0) && (dut.u_chk.fail_cnt == 0))
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== tcore_fmac_tx.f ====
verilog/tcore_pkg.sv
verilog/tx_ingress.sv
verilog/tx_pkt_fifo.sv
verilog/xgmii_tx_encap.sv
verilog/tcore_fmac_tx.sv
tb/tcore_fmac_tx_checker.sv
tb/tb_tcore_fmac_tx.sv
